// File: design/cpu8008_defines.svh
`ifndef CPU8008_DEFINES_SVH
`define CPU8008_DEFINES_SVH

// Data path and external bus width.
`define CPU_DATA_W 8
// Program counter width.
`define CPU_ADDR_W 14

// Scratchpad registers A, B, C, D, E, H, L.
`define CPU_NUM_REGS 7
`define CPU_REG_SEL_W 3
`define CPU_FLAG_W 4 // Carry, zero, sign, parity from bit 0 up.

`endif

// File: design/cpu8008_pkg.sv
package cpu8008_pkg;

	//////////////////////////////////////////////////////////////////////
	// External state codes, as seen on the state pins.
	//////////////////////////////////////////////////////////////////////
	typedef enum logic [2:0] {
		WAIT    = 3'b000,
		T3      = 3'b001,
		T1      = 3'b010,
		STOPPED = 3'b011,
		T2      = 3'b100,
		T5      = 3'b101,
		T4      = 3'b111
	} t_state_e;

	// Machine cycle type, sent in T2 on bits 7:6.
	typedef enum logic [1:0] {
		PCI = 2'b00, // Instruction fetch.
		PCR = 2'b01, // Immediate read.
		PCC = 2'b10  // Output command.
	} cycle_e;

	typedef enum logic [2:0] {
		BUS_NONE,
		BUS_PC_LOW,
		BUS_PC_HIGH,
		BUS_REG,
		BUS_ALU,
		BUS_TMP_A,
		BUS_TMP_B,
		BUS_DATA_IN
	} bus_src_e;

	// The first eight follow the PPP field of the ALU opcodes.
	typedef enum logic [3:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB,
		ALU_AND, ALU_XOR, ALU_OR, ALU_CMP,
		ALU_INR, ALU_DCR,
		ALU_RLC, ALU_RRC, ALU_RAL, ALU_RAR
	} alu_op_e;

endpackage

// File: design/datapath_ctrl_if.sv
`include "cpu8008_defines.svh"

interface datapath_ctrl_if;
	cpu8008_pkg::bus_src_e bus_src;
	cpu8008_pkg::cycle_e cycle_type;
	logic [`CPU_REG_SEL_W-1:0] reg_sel;
	logic reg_wr;
	logic tmp_a_ld;
	logic tmp_b_ld;
	logic ir_ld;
	logic pc_inc;
	cpu8008_pkg::alu_op_e alu_op;
	logic alu_go; // Also writes the flags.

	// Returned by the datapath.
	logic [`CPU_DATA_W-1:0] instr;
	logic ready_sync;

	modport sequencer (
		output bus_src, cycle_type, reg_sel, reg_wr, tmp_a_ld, tmp_b_ld,
		output ir_ld, pc_inc, alu_op, alu_go,
		input instr, ready_sync
	);

	modport datapath (
		input bus_src, cycle_type, reg_sel, reg_wr, tmp_a_ld, tmp_b_ld,
		input ir_ld, pc_inc, alu_op, alu_go,
		output instr, ready_sync
	);
endinterface

// File: design/alu.sv
`include "cpu8008_defines.svh"

module alu (
	input logic clk,
	input logic rst,
	input logic [`CPU_DATA_W-1:0] a,
	input logic [`CPU_DATA_W-1:0] b,
	input cpu8008_pkg::alu_op_e op,
	input logic go,
	output logic [`CPU_DATA_W-1:0] result
);
	logic [`CPU_FLAG_W-1:0] flags_q;
	logic [`CPU_FLAG_W-1:0] flags_d;
	logic [`CPU_DATA_W:0] wide; // Carry out on top.
	logic carry;

	assign carry = flags_q[0];

	always_comb begin
		case (op)
			cpu8008_pkg::ALU_ADD: wide = {1'b0, a} + {1'b0, b};
			cpu8008_pkg::ALU_ADC: wide = {1'b0, a} + {1'b0, b} + 9'(carry);
			cpu8008_pkg::ALU_SUB: wide = {1'b0, a} - {1'b0, b};
			cpu8008_pkg::ALU_SBB: wide = {1'b0, a} - {1'b0, b} - 9'(carry);
			cpu8008_pkg::ALU_CMP: wide = {1'b0, a} - {1'b0, b};
			cpu8008_pkg::ALU_AND: wide = {1'b0, a & b};
			cpu8008_pkg::ALU_XOR: wide = {1'b0, a ^ b};
			cpu8008_pkg::ALU_OR: wide = {1'b0, a | b};
			cpu8008_pkg::ALU_INR: wide = {carry, a + 8'd1};
			cpu8008_pkg::ALU_DCR: wide = {carry, a - 8'd1};
			cpu8008_pkg::ALU_RLC: wide = {a[7], a[6:0], a[7]};
			cpu8008_pkg::ALU_RRC: wide = {a[0], a[0], a[7:1]};
			cpu8008_pkg::ALU_RAL: wide = {a[7], a[6:0], carry};
			cpu8008_pkg::ALU_RAR: wide = {a[0], carry, a[7:1]};
			default: wide = {carry, a};
		endcase

		// Parity, sign, zero, carry.
		flags_d = {~^wide[7:0], wide[7], wide[7:0] == 8'd0, wide[8]};
		if (op inside {cpu8008_pkg::ALU_RLC, cpu8008_pkg::ALU_RRC,
				cpu8008_pkg::ALU_RAL, cpu8008_pkg::ALU_RAR}) begin
			flags_d = {flags_q[3:1], wide[8]}; // Rotates touch carry only.
		end

		result = (op == cpu8008_pkg::ALU_CMP) ? a : wide[7:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			flags_q <= '0;
		end else if (go) begin
			flags_q <= flags_d;
		end
	end
endmodule

// File: design/register_file.sv
`include "cpu8008_defines.svh"

module register_file (
	input logic clk,
	input logic rst,
	input logic [`CPU_REG_SEL_W-1:0] sel,
	input logic wr,
	input logic [`CPU_DATA_W-1:0] wdata,
	output logic [`CPU_DATA_W-1:0] rdata,
	output logic [`CPU_DATA_W-1:0] acc
);
	logic [`CPU_DATA_W-1:0] regs [0:`CPU_NUM_REGS-1];
	logic [`CPU_REG_SEL_W-1:0] rd_idx;
	logic sel_valid;

	// Code 7 is the memory slot, which here aliases A.
	assign sel_valid = (sel < `CPU_REG_SEL_W'(`CPU_NUM_REGS));
	assign rd_idx = sel_valid ? sel : '0;
	assign rdata = regs[rd_idx];
	assign acc = regs[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr && sel_valid) begin
			regs[sel] <= wdata;
		end
	end
endmodule

// File: design/datapath.sv
`include "cpu8008_defines.svh"

module datapath (
	input logic clk,
	input logic rst,
	datapath_ctrl_if.datapath ctrl,
	input logic [`CPU_DATA_W-1:0] d_in,
	input logic ready,
	output logic [`CPU_DATA_W-1:0] d_out
);
	logic ready_meta;
	logic ready_q;
	logic [`CPU_DATA_W-1:0] ir_q;
	logic [`CPU_ADDR_W-1:0] pc_q;
	logic [`CPU_DATA_W-1:0] tmp_a;
	logic [`CPU_DATA_W-1:0] tmp_b;
	logic [`CPU_DATA_W-1:0] bus;
	logic [`CPU_DATA_W-1:0] alu_result;
	logic [`CPU_DATA_W-1:0] rf_rdata;
	logic [`CPU_DATA_W-1:0] acc;

	//////////////////////////////////////////////////////////////////////
	// READY synchronizer, IR and PC.
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst) begin
			ready_meta <= 1'b0;
			ready_q <= 1'b0;
			ir_q <= '0;
			pc_q <= '0;
		end else begin
			ready_meta <= ready;
			ready_q <= ready_meta;
			if (ctrl.ir_ld) ir_q <= d_in;
			if (ctrl.pc_inc) pc_q <= pc_q + 1'b1;
		end
	end

	assign ctrl.ready_sync = ready_q;
	// New opcode is visible to decode during its own T3.
	assign ctrl.instr = ctrl.ir_ld ? d_in : ir_q;

	always_ff @(posedge clk) begin
		if (ctrl.tmp_a_ld) begin
			// PC_LOW on the bus marks fetch T1, where A is latched.
			tmp_a <= (ctrl.bus_src == cpu8008_pkg::BUS_PC_LOW) ? acc : bus;
		end
		if (ctrl.tmp_b_ld) tmp_b <= bus;
	end

	//////////////////////////////////////////////////////////////////////
	// Internal bus.
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (ctrl.bus_src)
			cpu8008_pkg::BUS_PC_LOW: bus = pc_q[7:0];
			cpu8008_pkg::BUS_PC_HIGH: bus = {ctrl.cycle_type, pc_q[`CPU_ADDR_W-1:8]};
			cpu8008_pkg::BUS_REG: bus = rf_rdata;
			cpu8008_pkg::BUS_ALU: bus = alu_result;
			cpu8008_pkg::BUS_TMP_A: bus = tmp_a;
			cpu8008_pkg::BUS_TMP_B: begin
				// Output command carries its cycle code in the opcode byte.
				if (ctrl.cycle_type == cpu8008_pkg::PCC) begin
					bus = {ctrl.cycle_type, tmp_b[5:0]};
				end else begin
					bus = tmp_b;
				end
			end
			cpu8008_pkg::BUS_DATA_IN: bus = d_in;
			default: bus = '0;
		endcase
	end

	assign d_out = bus;

	alu u_alu (
		.clk(clk),
		.rst(rst),
		.a(tmp_a),
		.b(tmp_b),
		.op(ctrl.alu_op),
		.go(ctrl.alu_go),
		.result(alu_result)
	);

	register_file u_regs (
		.clk(clk),
		.rst(rst),
		.sel(ctrl.reg_sel),
		.wr(ctrl.reg_wr),
		.wdata(bus),
		.rdata(rf_rdata),
		.acc(acc)
	);
endmodule

// File: design/control_sequencer.sv
`include "cpu8008_defines.svh"

module control_sequencer (
	input logic clk,
	input logic rst,
	datapath_ctrl_if.sequencer ctrl,
	output logic sync,
	output cpu8008_pkg::t_state_e state
);
	cpu8008_pkg::t_state_e state_q;
	cpu8008_pkg::t_state_e state_d;
	cpu8008_pkg::cycle_e cycle_q;
	cpu8008_pkg::cycle_e cycle_d;

	logic [`CPU_REG_SEL_W-1:0] src_sel;
	logic [`CPU_REG_SEL_W-1:0] dst_sel;
	logic is_halt;
	logic is_mov;
	logic is_mvi;
	logic is_alu_r;
	logic is_alu_i;
	logic is_inr;
	logic is_dcr;
	logic is_rot;
	logic is_out;

	//////////////////////////////////////////////////////////////////////
	// Opcode classes.
	//////////////////////////////////////////////////////////////////////
	assign src_sel = ctrl.instr[2:0];
	assign dst_sel = ctrl.instr[5:3];

	assign is_halt  = (ctrl.instr[7:1] == 7'b0000000) || (ctrl.instr == 8'hff);
	assign is_mov   = (ctrl.instr[7:6] == 2'b11) && (ctrl.instr != 8'hff);
	assign is_alu_r = (ctrl.instr[7:6] == 2'b10);
	assign is_mvi   = (ctrl.instr[7:6] == 2'b00) && (ctrl.instr[2:0] == 3'b110);
	assign is_alu_i = (ctrl.instr[7:6] == 2'b00) && (ctrl.instr[2:0] == 3'b100);
	assign is_inr   = (ctrl.instr[7:6] == 2'b00) && (ctrl.instr[2:0] == 3'b000) &&
		(dst_sel != 3'b000);
	assign is_dcr   = (ctrl.instr[7:6] == 2'b00) && (ctrl.instr[2:0] == 3'b001) &&
		(dst_sel != 3'b000);
	assign is_rot   = (ctrl.instr[7:5] == 3'b000) && (ctrl.instr[2:0] == 3'b010);
	assign is_out   = (ctrl.instr[7:6] == 2'b01) && ctrl.instr[0] &&
		(ctrl.instr[5:4] != 2'b00);

	assign ctrl.cycle_type = cycle_q;
	assign ctrl.ir_ld = (state_q == cpu8008_pkg::T3) && (cycle_q == cpu8008_pkg::PCI);

	assign sync = (state_q == cpu8008_pkg::T1) || (state_q == cpu8008_pkg::T2);
	assign state = state_q;

	//////////////////////////////////////////////////////////////////////
	// Next state and strobes.
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		state_d = state_q;
		cycle_d = cycle_q;
		ctrl.bus_src = cpu8008_pkg::BUS_NONE;
		ctrl.reg_sel = '0;
		ctrl.reg_wr = 1'b0;
		ctrl.tmp_a_ld = 1'b0;
		ctrl.tmp_b_ld = 1'b0;
		ctrl.pc_inc = 1'b0;
		ctrl.alu_op = cpu8008_pkg::ALU_ADD;
		ctrl.alu_go = 1'b0;
		case (state_q)
			cpu8008_pkg::T1: begin
				state_d = cpu8008_pkg::T2;
				if (cycle_q == cpu8008_pkg::PCC) begin
					ctrl.bus_src = cpu8008_pkg::BUS_TMP_A; // Accumulator out.
				end else begin
					ctrl.bus_src = cpu8008_pkg::BUS_PC_LOW;
					ctrl.tmp_a_ld = (cycle_q == cpu8008_pkg::PCI);
				end
			end
			cpu8008_pkg::T2: begin
				state_d = ctrl.ready_sync ? cpu8008_pkg::T3 : cpu8008_pkg::WAIT;
				if (cycle_q == cpu8008_pkg::PCC) begin
					ctrl.bus_src = cpu8008_pkg::BUS_TMP_B;
				end else begin
					ctrl.bus_src = cpu8008_pkg::BUS_PC_HIGH;
					ctrl.pc_inc = 1'b1;
				end
			end
			cpu8008_pkg::WAIT: begin
				state_d = ctrl.ready_sync ? cpu8008_pkg::T3 : cpu8008_pkg::WAIT;
			end
			cpu8008_pkg::T3: begin
				if (cycle_q == cpu8008_pkg::PCC) begin
					state_d = cpu8008_pkg::T1;
					cycle_d = cpu8008_pkg::PCI;
				end else begin
					// Opcode or immediate byte lands in temp B.
					ctrl.bus_src = cpu8008_pkg::BUS_DATA_IN;
					ctrl.tmp_b_ld = 1'b1;
					state_d = cpu8008_pkg::T4;
					if (cycle_q == cpu8008_pkg::PCI) begin
						if (is_halt) begin
							state_d = cpu8008_pkg::STOPPED;
						end else if (is_mvi || is_alu_i) begin
							state_d = cpu8008_pkg::T1;
							cycle_d = cpu8008_pkg::PCR;
						end else if (is_out) begin
							state_d = cpu8008_pkg::T1;
							cycle_d = cpu8008_pkg::PCC;
						end
					end
				end
			end
			cpu8008_pkg::T4: begin
				state_d = cpu8008_pkg::T5;
				if (cycle_q == cpu8008_pkg::PCI) begin
					if (is_mov || is_alu_r) begin
						ctrl.bus_src = cpu8008_pkg::BUS_REG;
						ctrl.reg_sel = src_sel;
						ctrl.tmp_b_ld = 1'b1;
					end else if (is_inr || is_dcr) begin
						ctrl.bus_src = cpu8008_pkg::BUS_REG;
						ctrl.reg_sel = dst_sel;
						ctrl.tmp_a_ld = 1'b1;
					end
				end
			end
			cpu8008_pkg::T5: begin
				state_d = cpu8008_pkg::T1;
				cycle_d = cpu8008_pkg::PCI;
				if (is_mov || is_mvi) begin
					ctrl.bus_src = cpu8008_pkg::BUS_TMP_B;
					ctrl.reg_sel = dst_sel;
					ctrl.reg_wr = 1'b1;
				end else if (is_alu_r || is_alu_i) begin
					ctrl.bus_src = cpu8008_pkg::BUS_ALU;
					ctrl.alu_op = cpu8008_pkg::alu_op_e'({1'b0, ctrl.instr[5:3]});
					ctrl.alu_go = 1'b1;
					ctrl.reg_wr = 1'b1; // Result goes to A.
				end else if (is_inr || is_dcr) begin
					ctrl.bus_src = cpu8008_pkg::BUS_ALU;
					ctrl.alu_op = is_inr ? cpu8008_pkg::ALU_INR : cpu8008_pkg::ALU_DCR;
					ctrl.alu_go = 1'b1;
					ctrl.reg_sel = dst_sel;
					ctrl.reg_wr = 1'b1;
				end else if (is_rot) begin
					ctrl.bus_src = cpu8008_pkg::BUS_ALU;
					case (ctrl.instr[4:3])
						2'b00: ctrl.alu_op = cpu8008_pkg::ALU_RLC;
						2'b01: ctrl.alu_op = cpu8008_pkg::ALU_RRC;
						2'b10: ctrl.alu_op = cpu8008_pkg::ALU_RAL;
						default: ctrl.alu_op = cpu8008_pkg::ALU_RAR;
					endcase
					ctrl.alu_go = 1'b1;
					ctrl.reg_wr = 1'b1;
				end
			end
			default: begin
				state_d = cpu8008_pkg::STOPPED; // Only reset leaves here.
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= cpu8008_pkg::T1;
			cycle_q <= cpu8008_pkg::PCI;
		end else begin
			state_q <= state_d;
			cycle_q <= cycle_d;
		end
	end
endmodule

// File: design/cpu8008_top.sv
`include "cpu8008_defines.svh"

module cpu8008_top (
	input logic clk,
	input logic rst,
	input logic [`CPU_DATA_W-1:0] d_in,
	input logic ready,
	output logic [`CPU_DATA_W-1:0] d_out,
	output logic sync,
	output logic [2:0] state
);
	// Strobes from the sequencer, opcode and READY back.
	datapath_ctrl_if u_ctrl_if ();

	control_sequencer u_sequencer (
		.clk(clk),
		.rst(rst),
		.ctrl(u_ctrl_if.sequencer),
		.sync(sync),
		.state(state)
	);

	datapath u_datapath (
		.clk(clk),
		.rst(rst),
		.ctrl(u_ctrl_if.datapath),
		.d_in(d_in),
		.ready(ready),
		.d_out(d_out)
	);
endmodule

// File: dv/cpu8008_assertions.sv
module cpu8008_assertions (
	input logic clk,
	input logic rst,
	input logic sync,
	input logic [2:0] state
);
	timeunit 1ns;
	timeprecision 100ps;

	// Reset always releases into T1 of a fetch.
	a_t1_after_reset: assert property (@(posedge clk) $fell(rst) |-> state == cpu8008_pkg::T1)
		else $error("state is not T1 one clock after reset");

	a_sync_decode: assert property (@(posedge clk) disable iff (rst)
		sync == ((state == cpu8008_pkg::T1) || (state == cpu8008_pkg::T2)))
		else $error("sync does not match T1 and T2");

	a_legal_state: assert property (@(posedge clk) disable iff (rst) state != 3'b110)
		else $error("state holds an illegal code");

	// Nothing but reset wakes the core.
	a_stopped_holds: assert property (@(posedge clk) disable iff (rst)
		state == cpu8008_pkg::STOPPED |=> state == cpu8008_pkg::STOPPED)
		else $error("core left STOPPED without reset");
endmodule

bind cpu8008_top cpu8008_assertions u_assertions (
	.clk(clk),
	.rst(rst),
	.sync(sync),
	.state(state)
);

// File: dv/tb_top.sv
`include "cpu8008_defines.svh"

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 5;
	localparam int HALT_HOLD = 20;
	localparam int NUM_ROWS = 28;
	localparam int LIMIT = NUM_ROWS * 40 + NUM_ROWS * RESET_CYCLES;

	localparam logic [3:0] K_ALU_R = 4'd0, K_ALU_I = 4'd1, K_MOV = 4'd2, K_INR = 4'd3;
	localparam logic [3:0] K_DCR = 4'd4, K_ROT = 4'd5, K_CHAIN = 4'd6, K_HALT = 4'd7;
	// ALU op codes, the first eight match the PPP field.
	localparam logic [3:0] O_ADD = 4'd0, O_ADC = 4'd1, O_SUB = 4'd2, O_SBB = 4'd3;
	localparam logic [3:0] O_AND = 4'd4, O_XOR = 4'd5, O_OR = 4'd6, O_CMP = 4'd7;
	localparam logic [3:0] O_INR = 4'd8, O_DCR = 4'd9, O_RLC = 4'd10, O_RRC = 4'd11;
	localparam logic [3:0] O_RAL = 4'd12, O_RAR = 4'd13;
	localparam logic [7:0] OUT_OP = 8'h53;

	////////////////////////////////////////////////////////////////////////
	// Kind, op, carry preload, operand a, operand b.
	////////////////////////////////////////////////////////////////////////
	localparam logic [24:0] TABLE [NUM_ROWS] = '{
		{K_ALU_R, O_ADD, 1'b0, 8'h3c, 8'h4a}, {K_ALU_R, O_ADD, 1'b0, 8'hf0, 8'h20},
		{K_ALU_R, O_ADC, 1'b1, 8'h10, 8'h20}, {K_ALU_R, O_SUB, 1'b0, 8'h20, 8'h30},
		{K_ALU_R, O_SBB, 1'b1, 8'h50, 8'h10}, {K_ALU_R, O_AND, 1'b0, 8'hca, 8'h0f},
		{K_ALU_R, O_XOR, 1'b0, 8'h5a, 8'hff}, {K_ALU_R, O_OR, 1'b0, 8'h81, 8'h18},
		{K_ALU_R, O_CMP, 1'b0, 8'h42, 8'h43}, {K_ALU_I, O_ADD, 1'b0, 8'h7f, 8'h01},
		{K_ALU_I, O_ADC, 1'b1, 8'hff, 8'h00}, {K_ALU_I, O_SUB, 1'b0, 8'h00, 8'h01},
		{K_ALU_I, O_SBB, 1'b1, 8'h05, 8'h05}, {K_ALU_I, O_AND, 1'b0, 8'h3c, 8'hf0},
		{K_ALU_I, O_XOR, 1'b0, 8'h99, 8'h66}, {K_ALU_I, O_OR, 1'b0, 8'h00, 8'h00},
		{K_ALU_I, O_CMP, 1'b1, 8'h10, 8'h01}, {K_MOV, O_ADD, 1'b0, 8'h96, 8'h00},
		{K_INR, O_INR, 1'b0, 8'hff, 8'h00}, {K_DCR, O_DCR, 1'b0, 8'h00, 8'h00},
		{K_ROT, O_RLC, 1'b0, 8'h81, 8'h00}, {K_ROT, O_RRC, 1'b0, 8'h01, 8'h00},
		{K_ROT, O_RAL, 1'b1, 8'h40, 8'h00}, {K_ROT, O_RAR, 1'b1, 8'h02, 8'h00},
		{K_CHAIN, O_ADC, 1'b0, 8'hc8, 8'h50}, {K_HALT, O_ADD, 1'b0, 8'h00, 8'h00},
		{K_HALT, O_ADD, 1'b0, 8'h00, 8'h01}, {K_HALT, O_ADD, 1'b0, 8'h00, 8'hff}
	};

	logic clk;
	logic rst;
	logic [`CPU_DATA_W-1:0] d_in;
	logic ready;
	logic [`CPU_DATA_W-1:0] d_out;
	logic sync;
	logic [2:0] state;

	logic [7:0] mem [0:63];
	logic [1:0] cyc_exp [0:63]; // Expected cycle type per address.
	logic [5:0] plen;
	logic [7:0] t1_byte;
	logic [13:0] addr_q;
	logic [13:0] next_addr;
	logic [7:0] out_val;
	logic [7:0] out_cmd;
	logic [2:0] st_s;
	logic [2:0] prev_st;
	logic [2:0] rdy_hist; // READY as sampled on the last three edges.
	logic [31:0] seed;
	logic [31:0] rnd;
	logic out_seen;
	logic halted;
	int t1_count;
	int wait_count;
	int hold_cnt;
	int new_hold;
	int cycle_cnt;
	int errors;
	int failed_tests;

	cpu8008_top u_dut (
		.clk(clk),
		.rst(rst),
		.d_in(d_in),
		.ready(ready),
		.d_out(d_out),
		.sync(sync),
		.state(state)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return {17'd0, seed[30:16]};
	endfunction

	task automatic check(input string name, input logic [15:0] exp, input logic [15:0] got);
		if (exp !== got) begin
			$display("[ERROR] %s expected 0x%0h got 0x%0h", name, exp, got);
			errors++;
		end
	endtask

	// Reference ALU: result and carry out.
	function automatic logic [7:0] alu_model(input logic [3:0] op, input logic [7:0] a,
			input logic [7:0] b, input logic cin, output logic cout);
		int sum;
		logic [7:0] res;
		res = a;
		cout = cin;
		case (op)
			O_ADD, O_ADC: begin
				sum = int'(a) + int'(b);
				if (op == O_ADC) sum = sum + int'(cin);
				res = sum[7:0];
				cout = (sum > 255);
			end
			O_SUB, O_SBB, O_CMP: begin
				sum = int'(a) - int'(b); // Borrow shows as a negative sum.
				if (op == O_SBB) sum = sum - int'(cin);
				if (op != O_CMP) res = sum[7:0];
				cout = (sum < 0);
			end
			O_AND, O_XOR, O_OR: begin
				res = (op == O_AND) ? (a & b) : (op == O_XOR) ? (a ^ b) : (a | b);
				cout = 1'b0;
			end
			O_INR: res = a + 8'd1;
			O_DCR: res = a - 8'd1;
			O_RLC, O_RAL: begin
				cout = a[7];
				res = {a[6:0], (op == O_RLC) ? a[7] : cin};
			end
			O_RRC, O_RAR: begin
				cout = a[0];
				res = {(op == O_RRC) ? a[0] : cin, a[7:1]};
			end
			default: ;
		endcase
		return res;
	endfunction

	task automatic emit(input logic [7:0] value, input logic [1:0] cyc);
		mem[plen] = value;
		cyc_exp[plen] = cyc;
		plen = plen + 6'd1;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#2;
		rst = 1'b1;
		ready = 1'b1;
		hold_cnt = 0;
		new_hold = 0;
		halted = 1'b0;
		out_seen = 1'b0;
		next_addr = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 rst = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////
	// Bus monitor and memory, sample at 1 ns and drive at 2 ns.
	////////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		#1;
		cycle_cnt++;
		if (cycle_cnt > LIMIT) begin
			$display("Timeout: the core stalled and the run stopped after %0d cycles", cycle_cnt);
			$display("*** TEST FAILED ***");
			$finish;
		end
		st_s = state;
		check("sync", 16'(st_s == cpu8008_pkg::T1 || st_s == cpu8008_pkg::T2), 16'(sync));
		if (rst) begin
			rdy_hist = '0;
		end else begin
			rdy_hist = {rdy_hist[1:0], ready};
			// READY reaches the sequencer two clocks late.
			if (prev_st == cpu8008_pkg::T2 || prev_st == cpu8008_pkg::WAIT) begin
				check("state", rdy_hist[2] ? 16'(cpu8008_pkg::T3) : 16'(cpu8008_pkg::WAIT),
					16'(st_s));
			end
		end
		prev_st = st_s;
		case (st_s)
			cpu8008_pkg::T1: begin
				t1_byte = d_out;
				t1_count++;
			end
			cpu8008_pkg::T2: begin
				if (d_out[7:6] == cpu8008_pkg::PCC) begin
					out_val = t1_byte;
					out_cmd = d_out;
					out_seen = 1'b1;
				end else begin
					addr_q = {d_out[5:0], t1_byte};
					check("address", 16'(next_addr), 16'(addr_q));
					check("cycle type", 16'(cyc_exp[addr_q[5:0]]), 16'(d_out[7:6]));
					next_addr = next_addr + 14'd1;
					rnd = next_rand();
					if (d_out[7:6] == cpu8008_pkg::PCI && hold_cnt == 0 && rnd[1:0] == 2'd0) begin
						rnd = next_rand();
						new_hold = int'(rnd[1:0]);
					end
				end
			end
			cpu8008_pkg::WAIT: wait_count++;
			cpu8008_pkg::STOPPED: halted = 1'b1;
			default: ;
		endcase
		#1;
		if (st_s == cpu8008_pkg::T3) d_in = mem[addr_q[5:0]];
		if (new_hold > 0) begin
			hold_cnt = new_hold;
			new_hold = 0;
			ready = 1'b0;
		end else if (hold_cnt > 0) begin
			hold_cnt--;
			if (hold_cnt == 0) ready = 1'b1;
		end
	end

	task automatic run_row(input logic [24:0] row, input int idx);
		logic [3:0] kind;
		logic [3:0] op;
		logic cin;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] exp;
		logic [7:0] r1;
		logic c1;
		logic c2;
		int err_before;
		int t1_before;
		{kind, op, cin, a, b} = row;
		err_before = errors;
		wait_count = 0;
		plen = '0;
		for (int k = 0; k < 64; k++) begin
			mem[k] = 8'(k) ^ 8'h5a;
			cyc_exp[k] = 2'b11;
		end
		if (cin) begin
			emit(8'h06, 2'b00); // MVI A then RLC leaves carry set.
			emit(8'h80, 2'b01);
			emit(8'h02, 2'b00);
		end
		exp = alu_model(op, a, b, cin, c1);
		case (kind)
			K_ALU_R, K_CHAIN: begin
				emit(8'h0e, 2'b00);
				emit(b, 2'b01);
				emit(8'h06, 2'b00);
				emit(a, 2'b01);
				if (kind == K_CHAIN) begin
					emit(8'h81, 2'b00);
					emit(8'h89, 2'b00);
					r1 = alu_model(O_ADD, a, b, 1'b0, c1);
					exp = alu_model(O_ADC, r1, b, c1, c2);
				end else begin
					emit({2'b10, op[2:0], 3'b001}, 2'b00);
				end
			end
			K_ALU_I: begin
				emit(8'h06, 2'b00);
				emit(a, 2'b01);
				emit({2'b00, op[2:0], 3'b100}, 2'b00);
				emit(b, 2'b01);
			end
			K_MOV: begin
				emit(8'h16, 2'b00); // C, then D, then A.
				emit(a, 2'b01);
				emit(8'hda, 2'b00);
				emit(8'hc3, 2'b00);
				exp = a;
			end
			K_INR, K_DCR: begin
				emit(8'h26, 2'b00);
				emit(a, 2'b01);
				emit((kind == K_INR) ? 8'h20 : 8'h21, 2'b00);
				emit(8'hc4, 2'b00);
			end
			K_ROT: begin
				emit(8'h06, 2'b00);
				emit(a, 2'b01);
				emit({3'b000, 2'(op - O_RLC), 3'b010}, 2'b00);
			end
			default: ;
		endcase
		if (kind != K_HALT) emit(OUT_OP, 2'b00);
		emit((kind == K_HALT) ? b : 8'hff, 2'b00);

		apply_reset();
		while (!halted) @(posedge clk);
		if (kind == K_HALT) begin
			t1_before = t1_count;
			repeat (HALT_HOLD) @(posedge clk);
			#2;
			check("state", 16'(cpu8008_pkg::STOPPED), 16'(state));
			check("T1 count", 16'(t1_before), 16'(t1_count));
		end else if (!out_seen) begin
			$display("Test %0d never reached the output cycle", idx);
			errors++;
		end else begin
			check("d_out", 16'(exp), 16'(out_val));
			check("out command", 16'({2'b10, OUT_OP[5:0]}), 16'(out_cmd));
		end
		if (errors != err_before) failed_tests++;
		$display("test %0d kind %0d op %0d: %s, %0d wait states", idx, kind, op,
			(errors == err_before) ? "ok" : "mismatch", wait_count);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		d_in = '0;
		ready = 1'b1;
		seed = 32'd55;
		errors = 0;
		failed_tests = 0;
		cycle_cnt = 0;
		t1_count = 0;
		hold_cnt = 0;
		new_hold = 0;
		halted = 1'b0;
		out_seen = 1'b0;
		next_addr = '0;
		addr_q = '0;
		rdy_hist = '0;
		prev_st = cpu8008_pkg::T1;
		for (int i = 0; i < NUM_ROWS; i++) begin
			run_row(TABLE[i], i);
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_ROWS,
			NUM_ROWS - failed_tests, failed_tests, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end
endmodule

// File: project.f
+incdir+design
design/cpu8008_pkg.sv
design/datapath_ctrl_if.sv
design/alu.sv
design/register_file.sv
design/datapath.sv
design/control_sequencer.sv
design/cpu8008_top.sv
dv/cpu8008_assertions.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module tb_top -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qF "*** TEST PASSED ***" &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
